/* verilog/CoreTypesPkg.sv */
package CoreTypesPkg;

    localparam int SQN_WIDTH = 7;
    localparam int TAG_WIDTH = 7;
    localparam int REG_NM_WIDTH = 5;

    // Sequence numbers wrap around.
    // Two of them are ordered by the sign of their difference, never by magnitude.
    typedef logic [SQN_WIDTH-1:0] SqN;

    typedef logic [TAG_WIDTH-1:0] Tag; // physical destination register.

    typedef logic [REG_NM_WIDTH-1:0] RegNm; // architectural destination register.

endpackage

/* verilog/MulOpsPkg.sv */
package MulOpsPkg;

    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULSU,
        MULU
    } MulOp;

    typedef struct packed {
        logic [31:0]        srcA; // magnitude of source A.
        logic [31:0]        srcB; // magnitude of source B.
        logic [63:0]        res; // running sum of the slice products.
        logic               invert; // product must be negated at the end.
        logic               high; // return the upper word.
        CoreTypesPkg::Tag   tagDst;
        CoreTypesPkg::RegNm nmDst;
        logic [31:0]        pc;
    } MulState;

    typedef struct packed {
        logic [31:0]        result;
        CoreTypesPkg::Tag   tagDst;
        CoreTypesPkg::RegNm nmDst;
        logic [31:0]        pc;
    } MulResult;

endpackage

/* verilog/SquashStage.sv */
`timescale 1ns/1ps

module SquashStage #(
    parameter type Payload = logic
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             branchTaken,
    input  CoreTypesPkg::SqN branchSqN,
    input  logic             inValid,
    input  CoreTypesPkg::SqN inSqN,
    input  Payload           inData,
    output logic             outValid,
    output CoreTypesPkg::SqN outSqN,
    output Payload           outData
);

    CoreTypesPkg::SqN ageDiff;
    logic squash;
    logic keep;

    assign ageDiff = inSqN - branchSqN; // the sign of this modulo difference gives relative age.
    assign squash = branchTaken && ($signed(ageDiff) > 0); // entry is younger than the branch.
    assign keep = inValid && !squash;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= keep;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            outSqN <= inSqN;
            outData <= inData;
        end
    end

    assert property (@(posedge clk) rst |=> !outValid)
        else $error("pipeline entry valid in the cycle after reset");

endmodule

/* verilog/MulOperandPrep.sv */
`timescale 1ns/1ps

module MulOperandPrep (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 inValid,
    input  MulOpsPkg::MulOp      inOp,
    input  logic [31:0]          inSrcA,
    input  logic [31:0]          inSrcB,
    input  CoreTypesPkg::Tag     inTag,
    input  CoreTypesPkg::RegNm   inRegNm,
    input  CoreTypesPkg::SqN     inSqN,
    input  logic [31:0]          inPc,
    input  logic                 branchTaken,
    input  CoreTypesPkg::SqN     branchSqN,
    output logic                 outValid,
    output CoreTypesPkg::SqN     outSqN,
    output MulOpsPkg::MulState   outState
);

    MulOpsPkg::MulState prepState;
    logic [31:0] absA;
    logic [31:0] absB;
    logic accept;

    assign absA = inSrcA[31] ? -inSrcA : inSrcA;
    assign absB = inSrcB[31] ? -inSrcB : inSrcB;
    assign accept = inValid && en; // a strobe while disabled is lost.

    always_comb begin
        prepState.srcA = inSrcA;
        prepState.srcB = inSrcB;
        prepState.invert = 1'b0;
        prepState.res = 64'd0;
        prepState.tagDst = inTag;
        prepState.nmDst = inRegNm;
        prepState.pc = inPc;
        case (inOp)
            MulOpsPkg::MULH: begin
                prepState.srcA = absA;
                prepState.srcB = absB;
                prepState.invert = inSrcA[31] ^ inSrcB[31];
            end
            MulOpsPkg::MULSU: begin
                prepState.srcA = absA; // B is unsigned here.
                prepState.invert = inSrcA[31];
            end
            default: begin
            end
        endcase
        prepState.high = (inOp != MulOpsPkg::MUL);
    end

    SquashStage #(.Payload(MulOpsPkg::MulState)) stageReg (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .inValid(accept),
        .inSqN(inSqN),
        .inData(prepState),
        .outValid(outValid),
        .outSqN(outSqN),
        .outData(outState)
    );

    assert property (@(posedge clk) disable iff (rst) accept |-> !$isunknown(inOp))
        else $error("multiply issued with an unknown opcode");

endmodule

/* verilog/MulAccumStage.sv */
`timescale 1ns/1ps

module MulAccumStage #(
    parameter int BITS = 8,
    parameter int STAGE_IDX = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               branchTaken,
    input  CoreTypesPkg::SqN   branchSqN,
    input  logic               inValid,
    input  CoreTypesPkg::SqN   inSqN,
    input  MulOpsPkg::MulState inState,
    output logic               outValid,
    output CoreTypesPkg::SqN   outSqN,
    output MulOpsPkg::MulState outState
);

    localparam int SHIFT = STAGE_IDX * BITS;

    logic [BITS-1:0] sliceB;
    logic [31+BITS:0] sliceProd;
    logic [63:0] partial;
    MulOpsPkg::MulState nextState;

    assign sliceB = inState.srcB[SHIFT +: BITS];
    assign sliceProd = inState.srcA * sliceB;
    assign partial = 64'(sliceProd) << SHIFT; // weight of this slice of B.

    always_comb begin
        nextState = inState;
        nextState.res = inState.res + partial;
    end

    SquashStage #(.Payload(MulOpsPkg::MulState)) stageReg (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .inValid(inValid),
        .inSqN(inSqN),
        .inData(nextState),
        .outValid(outValid),
        .outSqN(outSqN),
        .outData(outState)
    );

endmodule

/* verilog/MulResultSelect.sv */
`timescale 1ns/1ps

module MulResultSelect (
    input  logic               clk,
    input  logic               rst,
    input  logic               branchTaken,
    input  CoreTypesPkg::SqN   branchSqN,
    input  logic               inValid,
    input  CoreTypesPkg::SqN   inSqN,
    input  MulOpsPkg::MulState inState,
    output logic               outValid,
    output CoreTypesPkg::SqN   outSqN,
    output logic [31:0]        outResult,
    output CoreTypesPkg::Tag   outTag,
    output CoreTypesPkg::RegNm outRegNm,
    output logic [31:0]        outPc
);

    logic [31:0] lowWord;
    logic [31:0] highWord;
    logic lowZero;
    MulOpsPkg::MulResult nextResult;
    MulOpsPkg::MulResult heldResult;

    assign lowWord = inState.res[31:0];
    assign highWord = inState.res[63:32];
    assign lowZero = (lowWord == 32'd0);

    always_comb begin
        nextResult.tagDst = inState.tagDst;
        nextResult.nmDst = inState.nmDst;
        nextResult.pc = inState.pc;
        if (!inState.high) begin
            nextResult.result = lowWord;
        end else if (!inState.invert) begin
            nextResult.result = highWord;
        end else begin
            // Two's complement of the full product, upper half only.
            // The carry out of the low word exists only when that word is zero.
            nextResult.result = ~highWord + {31'd0, lowZero};
        end
    end

    SquashStage #(.Payload(MulOpsPkg::MulResult)) stageReg (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .inValid(inValid),
        .inSqN(inSqN),
        .inData(nextResult),
        .outValid(outValid),
        .outSqN(outSqN),
        .outData(heldResult)
    );

    assign outResult = heldResult.result;
    assign outTag = heldResult.tagDst;
    assign outRegNm = heldResult.nmDst;
    assign outPc = heldResult.pc;

endmodule

/* verilog/Multiply.sv */
`timescale 1ns/1ps

module Multiply #(
    parameter int NUM_STAGES = 4,
    parameter int BITS = 32 / NUM_STAGES
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               inValid,
    input  MulOpsPkg::MulOp    inOp,
    input  logic [31:0]        inSrcA,
    input  logic [31:0]        inSrcB,
    input  CoreTypesPkg::Tag   inTag,
    input  CoreTypesPkg::RegNm inRegNm,
    input  CoreTypesPkg::SqN   inSqN,
    input  logic [31:0]        inPc,
    input  logic               branchTaken,
    input  CoreTypesPkg::SqN   branchSqN,
    output logic               outValid,
    output logic [31:0]        outResult,
    output CoreTypesPkg::Tag   outTag,
    output CoreTypesPkg::RegNm outRegNm,
    output CoreTypesPkg::SqN   outSqN,
    output logic [31:0]        outPc
);

    // Slot k is the output of stage k-1 and slot 0 comes from the operand stage.
    logic               stValid [0:NUM_STAGES];
    CoreTypesPkg::SqN   stSqN [0:NUM_STAGES];
    MulOpsPkg::MulState stState [0:NUM_STAGES];

    MulOperandPrep operandPrep (
        .clk(clk),
        .rst(rst),
        .en(en),
        .inValid(inValid),
        .inOp(inOp),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inTag(inTag),
        .inRegNm(inRegNm),
        .inSqN(inSqN),
        .inPc(inPc),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .outValid(stValid[0]),
        .outSqN(stSqN[0]),
        .outState(stState[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : genAccum
        MulAccumStage #(
            .BITS(BITS),
            .STAGE_IDX(k)
        ) accumStage (
            .clk(clk),
            .rst(rst),
            .branchTaken(branchTaken),
            .branchSqN(branchSqN),
            .inValid(stValid[k]),
            .inSqN(stSqN[k]),
            .inState(stState[k]),
            .outValid(stValid[k+1]),
            .outSqN(stSqN[k+1]),
            .outState(stState[k+1])
        );
    end

    MulResultSelect resultSelect (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .inValid(stValid[NUM_STAGES]),
        .inSqN(stSqN[NUM_STAGES]),
        .inState(stState[NUM_STAGES]),
        .outValid(outValid),
        .outSqN(outSqN),
        .outResult(outResult),
        .outTag(outTag),
        .outRegNm(outRegNm),
        .outPc(outPc)
    );

    assert property (@(posedge clk) disable iff (rst) outValid |-> !$isunknown(outResult))
        else $error("multiply result has unknown bits");

endmodule

/* verif/MultiplyTb.sv */
`timescale 1ns/1ps

module MultiplyTb;

    localparam int NUM_STAGES = 4;
    localparam int LATENCY = NUM_STAGES + 2; // issue cycle to the cycle outValid is seen.
    localparam int DRAIN_LIMIT = LATENCY + 10;
    localparam logic [31:0] CORNERS [5] = '{
        32'd0, 32'd1, 32'hFFFFFFFF, 32'h80000000, 32'h7FFFFFFF
    };
    localparam MulOpsPkg::MulOp HIGH_OPS [3] = '{
        MulOpsPkg::MULH, MulOpsPkg::MULSU, MulOpsPkg::MULU
    };

    typedef struct packed {
        logic [31:0]        result;
        CoreTypesPkg::Tag   tag;
        CoreTypesPkg::RegNm regNm;
        CoreTypesPkg::SqN   sqN;
        logic [31:0]        pc;
        int                 issueCycle;
    } Expected;

    logic clk = 1'b0;
    logic rst;
    logic en;
    logic inValid;
    MulOpsPkg::MulOp inOp;
    logic [31:0] inSrcA;
    logic [31:0] inSrcB;
    CoreTypesPkg::Tag inTag;
    CoreTypesPkg::RegNm inRegNm;
    CoreTypesPkg::SqN inSqN;
    logic [31:0] inPc;
    logic branchTaken;
    CoreTypesPkg::SqN branchSqN;
    logic outValid;
    logic [31:0] outResult;
    CoreTypesPkg::Tag outTag;
    CoreTypesPkg::RegNm outRegNm;
    CoreTypesPkg::SqN outSqN;
    logic [31:0] outPc;

    Expected expQ[$];
    int seed = 32'ha0d27328;
    int cycle = 0;
    int squashed = 0;
    CoreTypesPkg::SqN nextSqN = '0;
    string testName = "reset";

    Multiply #(.NUM_STAGES(NUM_STAGES), .BITS(32 / NUM_STAGES)) i_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkField(input string field, input logic [31:0] expv,
                              input logic [31:0] actv);
        assert (actv === expv) else stopOnError($sformatf("MISMATCH %s %s: expected %h, actual %h",
            testName, field, expv, actv));
    endtask

    // widen each source by the signedness of its opcode, then take one word of the product.
    function automatic logic [31:0] expectedResult(input MulOpsPkg::MulOp op,
                                                   input logic [31:0] a, input logic [31:0] b);
        logic [63:0] wideA;
        logic [63:0] wideB;
        logic [63:0] prod;
        wideA = (op == MulOpsPkg::MULH || op == MulOpsPkg::MULSU) ? {{32{a[31]}}, a} : {32'd0, a};
        wideB = (op == MulOpsPkg::MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        prod = wideA * wideB;
        return (op == MulOpsPkg::MUL) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic isYounger(input CoreTypesPkg::SqN sqN,
                                       input CoreTypesPkg::SqN refSqN);
        logic signed [CoreTypesPkg::SQN_WIDTH-1:0] diff;
        diff = sqN - refSqN;
        return diff > 0;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
        inValid = 1'b0;
        branchTaken = 1'b0;
    endtask

    task automatic issueOp(input MulOpsPkg::MulOp op, input logic [31:0] a, input logic [31:0] b);
        Expected e;
        logic [31:0] r;
        r = $random(seed);
        inValid = 1'b1;
        inOp = op;
        inSrcA = a;
        inSrcB = b;
        inTag = r[6:0];
        inRegNm = r[11:7];
        inSqN = nextSqN;
        inPc = {r[31:14], 14'h0} ^ {16'h0, r[15:2], 2'b00};
        e = '{expectedResult(op, a, b), inTag, inRegNm, inSqN, inPc, cycle};
        if (en && !(branchTaken && isYounger(inSqN, branchSqN))) begin
            expQ.push_back(e); // lost otherwise.
        end
        nextSqN++;
        nextCycle();
    endtask

    // Drops every expected entry still inside the pipeline that is younger than the branch.
    task automatic raiseBranch(input CoreTypesPkg::SqN sqN);
        Expected kept[$];
        Expected e;
        branchTaken = 1'b1;
        branchSqN = sqN;
        while (expQ.size() > 0) begin
            e = expQ.pop_front();
            if (cycle - e.issueCycle < LATENCY && isYounger(e.sqN, sqN)) squashed++;
            else kept.push_back(e);
        end
        expQ = kept;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQ.size() > 0 && waited < DRAIN_LIMIT) begin
            nextCycle();
            waited++;
        end
        assert (expQ.size() == 0) else stopOnError($sformatf(
            "%0d results of test %s never came out of the pipeline", expQ.size(), testName));
    endtask

    always @(negedge clk) begin
        Expected e;
        if (!rst && outValid === 1'b1) begin
            assert (expQ.size() != 0) else stopOnError($sformatf(
                "test %s got a result for sequence number %0d with nothing pending",
                testName, outSqN));
            e = expQ.pop_front();
            checkField("result", e.result, outResult);
            checkField("tag", {25'd0, e.tag}, {25'd0, outTag});
            checkField("regNm", {27'd0, e.regNm}, {27'd0, outRegNm});
            checkField("sqN", {25'd0, e.sqN}, {25'd0, outSqN});
            checkField("pc", e.pc, outPc);
            checkField("latency", LATENCY, cycle - e.issueCycle);
        end
    end

    initial begin
        #100000;
        stopOnError("simulation ran past its time limit");
    end

    initial begin
        logic [31:0] r;
        CoreTypesPkg::SqN offset;
        rst = 1'b1;
        en = 1'b1;
        inValid = 1'b0;
        inOp = MulOpsPkg::MUL;
        inSrcA = '0;
        inSrcB = '0;
        inTag = '0;
        inRegNm = '0;
        inSqN = '0;
        inPc = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        testName = "idle after reset";
        repeat (10) begin
            assert (outValid === 1'b0) else stopOnError("outValid rose with no micro-op issued");
            nextCycle();
        end

        testName = "mul random";
        repeat (200) issueOp(MulOpsPkg::MUL, $random(seed), $random(seed));
        waitDrain();

        testName = "high words";
        foreach (HIGH_OPS[k]) begin
            foreach (CORNERS[i]) begin
                foreach (CORNERS[j]) begin
                    issueOp(HIGH_OPS[k], CORNERS[i], CORNERS[j]);
                end
            end
            repeat (40) issueOp(HIGH_OPS[k], $random(seed), $random(seed));
        end
        waitDrain();

        testName = "branch squash";
        nextSqN = 7'h78; // wraps within the first round.
        for (int k = 0; k < 14; k++) begin
            repeat (8) begin
                r = $random(seed);
                issueOp(MulOpsPkg::MulOp'(r[1:0]), $random(seed), CORNERS[r[4:2] % 5] ^ r);
            end
            offset = CoreTypesPkg::SqN'(k % 7); // from the incoming op back to one already done.
            raiseBranch(nextSqN - offset);
            issueOp(MulOpsPkg::MULH, $random(seed), $random(seed));
        end
        waitDrain();
        assert (squashed > 0) else stopOnError("no micro-op was ever squashed by a branch");

        testName = "disabled issue";
        en = 1'b0;
        repeat (5) issueOp(MulOpsPkg::MULU, $random(seed), $random(seed));
        en = 1'b1;
        repeat (DRAIN_LIMIT) nextCycle();

        if (expQ.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stopOnError("expected results remain at the end of the run");
        end
    end

endmodule

/* files.f */
verilog/CoreTypesPkg.sv
verilog/MulOpsPkg.sv
verilog/SquashStage.sv
verilog/MulOperandPrep.sv
verilog/MulAccumStage.sv
verilog/MulResultSelect.sv
verilog/Multiply.sv
verif/MultiplyTb.sv

/* Makefile */
TOP ?= MultiplyTb
LOG ?= sim.log
VERILATOR ?= verilator
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
